/* design/mipsPkg.sv */
package mipsPkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [15:0] halfword_t;
	typedef logic [4:0] cregAddr_t;

	// link register for jal
	localparam cregAddr_t RA_REG = 5'd31;
	// sll r0, r0, 0
	localparam word_t NOP_INSTR = 32'h0000_0000;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OPC_SPECIAL = 6'b000000,
		OPC_J       = 6'b000010,
		OPC_JAL     = 6'b000011,
		OPC_BEQ     = 6'b000100,
		OPC_BNE     = 6'b000101,
		OPC_ADDIU   = 6'b001001,
		OPC_SLTI    = 6'b001010,
		OPC_ANDI    = 6'b001100,
		OPC_ORI     = 6'b001101,
		OPC_XORI    = 6'b001110,
		OPC_LUI     = 6'b001111,
		OPC_COP0    = 6'b010000,
		OPC_LW      = 6'b100011,
		OPC_SW      = 6'b101011,
		OPC_CACHE   = 6'b101111
	} opcode_t;

	// special function field, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_JR   = 6'b001000,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} func_t;

	// one entry per supported instruction
	typedef enum logic [4:0] {
		DEC_SLL,
		DEC_SRL,
		DEC_JR,
		DEC_ADDU,
		DEC_SUBU,
		DEC_AND,
		DEC_OR,
		DEC_XOR,
		DEC_SLT,
		DEC_J,
		DEC_JAL,
		DEC_BEQ,
		DEC_BNE,
		DEC_ADDIU,
		DEC_SLTI,
		DEC_ANDI,
		DEC_ORI,
		DEC_XORI,
		DEC_LUI,
		DEC_LW,
		DEC_SW,
		DEC_CACHE,
		DEC_MFC0,
		DEC_MTC0,
		DEC_RESERVED
	} decodedOp_t;

	// per-instruction control bits
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branch;
		logic jump;
		logic jumpReg;
		logic aluSrcImm;
		logic zeroExt;
		logic link;
		logic useShamt;
		logic isCp0;
		logic isCache;
	} control_t;

	// bundle handed over by fetch
	typedef struct packed {
		word_t instr;
		word_t pcPlus4;
		// predicted taken
		logic pred;
		// jr target came from return stack top
		logic jrTop;
		logic exceptionInstr;
		logic instrTlbInvalid;
		logic instrTlbRefill;
	} fetch_data_t;

	typedef struct packed {
		decodedOp_t op;
		control_t ctl;
		logic [4:0] shamt;
		word_t extendedImm;
		word_t pcBranch;
		word_t pcJump;
		logic [4:0] cacheOp;
	} decodedInstr_t;

	// decoder results on their way to the latch
	typedef struct packed {
		decodedOp_t op;
		control_t ctl;
		cregAddr_t srcRegA;
		cregAddr_t srcRegB;
		cregAddr_t destReg;
		logic exceptionRi;
	} decodeFields_t;

	// registered output of decode
	typedef struct packed {
		decodedInstr_t instr;
		cregAddr_t srcRegA;
		cregAddr_t srcRegB;
		cregAddr_t destReg;
		cregAddr_t cp0Addr;
		logic [2:0] cp0Sel;
		logic exceptionRi;
		word_t pcPlus4;
		logic pred;
		logic jrTop;
		logic exceptionInstr;
		logic instrTlbInvalid;
		logic instrTlbRefill;
		logic inDelaySlot;
	} decode_data_t;

endpackage

/* design/mainDecode.sv */
`timescale 1ns/100ps

module mainDecode import mipsPkg::*; (
	input word_t instr,
	output decodedOp_t op,
	output control_t ctl,
	output cregAddr_t srcRegA,
	output cregAddr_t srcRegB,
	output cregAddr_t destReg,
	output logic exceptionRi
);

	opcode_t opcode;
	func_t func;
	cregAddr_t rs;
	cregAddr_t rt;
	cregAddr_t rd;

	// field slices
	assign opcode = opcode_t'(instr[31:26]);
	assign func = func_t'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	// opcode and function to operation
	always_comb begin
		op = DEC_RESERVED;
		case (opcode)
			OPC_SPECIAL: begin
				case (func)
					FN_SLL: op = DEC_SLL;
					FN_SRL: op = DEC_SRL;
					FN_JR: op = DEC_JR;
					FN_ADDU: op = DEC_ADDU;
					FN_SUBU: op = DEC_SUBU;
					FN_AND: op = DEC_AND;
					FN_OR: op = DEC_OR;
					FN_XOR: op = DEC_XOR;
					FN_SLT: op = DEC_SLT;
					default: op = DEC_RESERVED;
				endcase
			end
			OPC_J: op = DEC_J;
			OPC_JAL: op = DEC_JAL;
			OPC_BEQ: op = DEC_BEQ;
			OPC_BNE: op = DEC_BNE;
			OPC_ADDIU: op = DEC_ADDIU;
			OPC_SLTI: op = DEC_SLTI;
			OPC_ANDI: op = DEC_ANDI;
			OPC_ORI: op = DEC_ORI;
			OPC_XORI: op = DEC_XORI;
			OPC_LUI: op = DEC_LUI;
			OPC_LW: op = DEC_LW;
			OPC_SW: op = DEC_SW;
			OPC_CACHE: op = DEC_CACHE;
			OPC_COP0: begin
				// rs field picks mf / mt, anything else is reserved
				if (rs == 5'b00000) begin
					op = DEC_MFC0;
				end else if (rs == 5'b00100) begin
					op = DEC_MTC0;
				end
			end
			default: op = DEC_RESERVED;
		endcase
	end

	// controls and register selection per operation
	always_comb begin
		ctl = '0;
		srcRegA = '0;
		srcRegB = '0;
		destReg = '0;
		case (op)
			DEC_ADDU, DEC_SUBU, DEC_AND, DEC_OR, DEC_XOR, DEC_SLT: begin
				ctl.regWrite = 1'b1;
				srcRegA = rs;
				srcRegB = rt;
				destReg = rd;
			end
			DEC_SLL, DEC_SRL: begin
				// shifts take rt only, amount from shamt
				ctl.regWrite = 1'b1;
				ctl.useShamt = 1'b1;
				srcRegB = rt;
				destReg = rd;
			end
			DEC_JR: begin
				// target comes from rs, nothing written
				ctl.jump = 1'b1;
				ctl.jumpReg = 1'b1;
				srcRegA = rs;
			end
			DEC_J: begin
				ctl.jump = 1'b1;
			end
			DEC_JAL: begin
				ctl.jump = 1'b1;
				ctl.link = 1'b1;
				ctl.regWrite = 1'b1;
				destReg = RA_REG;
			end
			DEC_BEQ, DEC_BNE: begin
				ctl.branch = 1'b1;
				srcRegA = rs;
				srcRegB = rt;
			end
			DEC_ADDIU, DEC_SLTI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				srcRegA = rs;
				destReg = rt;
			end
			DEC_ANDI, DEC_ORI, DEC_XORI: begin
				// logical immediates are zero extended
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.zeroExt = 1'b1;
				srcRegA = rs;
				destReg = rt;
			end
			DEC_LUI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				destReg = rt;
			end
			DEC_LW: begin
				ctl.regWrite = 1'b1;
				ctl.memRead = 1'b1;
				ctl.aluSrcImm = 1'b1;
				srcRegA = rs;
				destReg = rt;
			end
			DEC_SW: begin
				ctl.memWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				srcRegA = rs;
				srcRegB = rt;
			end
			DEC_CACHE: begin
				// base in rs, rt field is the cache op
				ctl.isCache = 1'b1;
				ctl.aluSrcImm = 1'b1;
				srcRegA = rs;
			end
			DEC_MFC0: begin
				ctl.isCp0 = 1'b1;
				ctl.regWrite = 1'b1;
				destReg = rt;
			end
			DEC_MTC0: begin
				ctl.isCp0 = 1'b1;
				srcRegB = rt;
			end
			default: begin
				// reserved, all controls stay clear
				ctl = '0;
			end
		endcase
		// canonical nop never writes back
		if (instr == NOP_INSTR) begin
			ctl.regWrite = 1'b0;
		end
	end

	assign exceptionRi = (op == DEC_RESERVED);

endmodule

/* design/targetCalc.sv */
`timescale 1ns/100ps

module targetCalc import mipsPkg::*; (
	input word_t instr,
	input word_t pcPlus4,
	output word_t signImm,
	output word_t zeroImm,
	output word_t pcBranch,
	output word_t pcJump
);

	halfword_t imm;
	logic [25:0] jumpIndex;
	word_t branchOffset;

	assign imm = instr[15:0];
	assign jumpIndex = instr[25:0];

	// both extensions, latch picks one
	assign signImm = {{16{imm[15]}}, imm};
	assign zeroImm = {16'h0000, imm};

	// word offset relative to delay slot pc
	assign branchOffset = {signImm[29:0], 2'b00};
	assign pcBranch = pcPlus4 + branchOffset;

	// region bits from delay slot pc
	assign pcJump = {pcPlus4[31:28], jumpIndex, 2'b00};

endmodule

/* design/decodeLatch.sv */
`timescale 1ns/100ps

module decodeLatch import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input logic flush,
	input fetch_data_t dataF,
	input decodeFields_t decodeFields,
	input word_t signImm,
	input word_t zeroImm,
	input word_t pcBranch,
	input word_t pcJump,
	output logic decodeValid,
	output decode_data_t dataD
);

	decode_data_t nextD;

	// assemble next bundle
	always_comb begin
		nextD = '0;
		nextD.instr.op = decodeFields.op;
		nextD.instr.ctl = decodeFields.ctl;
		nextD.instr.shamt = dataF.instr[10:6];
		// extension chosen by decoder
		nextD.instr.extendedImm = decodeFields.ctl.zeroExt ? zeroImm : signImm;
		nextD.instr.pcBranch = pcBranch;
		nextD.instr.pcJump = pcJump;
		// cache op sits in the rt slot
		nextD.instr.cacheOp = dataF.instr[20:16];
		nextD.srcRegA = decodeFields.srcRegA;
		nextD.srcRegB = decodeFields.srcRegB;
		nextD.destReg = decodeFields.destReg;
		// cp0 register from rd, select from low bits
		nextD.cp0Addr = dataF.instr[15:11];
		nextD.cp0Sel = dataF.instr[2:0];
		nextD.exceptionRi = decodeFields.exceptionRi;
		// fetch side passthrough
		nextD.pcPlus4 = dataF.pcPlus4;
		nextD.pred = dataF.pred;
		nextD.jrTop = dataF.jrTop;
		nextD.exceptionInstr = dataF.exceptionInstr;
		nextD.instrTlbInvalid = dataF.instrTlbInvalid;
		nextD.instrTlbRefill = dataF.instrTlbRefill;
		// no delay slot tracking yet
		nextD.inDelaySlot = 1'b0;
	end

	// strobe follows capture by one cycle, killed by flush
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decodeValid <= 1'b0;
		end else begin
			decodeValid <= fetchValid & ~flush;
		end
	end

	// pipeline register, holds between strobes
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dataD <= '0;
		end else if (fetchValid) begin
			dataD <= nextD;
		end
	end

endmodule

/* design/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input logic flush,
	input fetch_data_t dataF,
	output logic decodeValid,
	output decode_data_t dataD
);

	decodeFields_t decodeFields;
	word_t signImm;
	word_t zeroImm;
	word_t pcBranch;
	word_t pcJump;

	// opcode / function decode
	mainDecode u_mainDecode (
		.instr(dataF.instr),
		.op(decodeFields.op),
		.ctl(decodeFields.ctl),
		.srcRegA(decodeFields.srcRegA),
		.srcRegB(decodeFields.srcRegB),
		.destReg(decodeFields.destReg),
		.exceptionRi(decodeFields.exceptionRi)
	);

	// immediates and targets in parallel
	targetCalc u_targetCalc (
		.instr(dataF.instr),
		.pcPlus4(dataF.pcPlus4),
		.signImm(signImm),
		.zeroImm(zeroImm),
		.pcBranch(pcBranch),
		.pcJump(pcJump)
	);

	// merge and register
	decodeLatch u_decodeLatch (
		.clk(clk),
		.arstN(arstN),
		.fetchValid(fetchValid),
		.flush(flush),
		.dataF(dataF),
		.decodeFields(decodeFields),
		.signImm(signImm),
		.zeroImm(zeroImm),
		.pcBranch(pcBranch),
		.pcJump(pcJump),
		.decodeValid(decodeValid),
		.dataD(dataD)
	);

endmodule

/* verif/decodeStage_checker.sv */
`timescale 1ns/100ps

module decodeStage_checker import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input logic flush,
	input logic decodeValid,
	input decode_data_t dataD
);

	// assertion failure count for the closing line
	int assertFails = 0;

	// unflushed strobe shows up exactly one cycle later
	strobeToValid: assert property (@(posedge clk) disable iff (!arstN)
		fetchValid && !flush |=> decodeValid)
	else begin
		$error("decodeValid missing one cycle after an unflushed strobe");
		assertFails++;
	end

	// no strobe, or a flushed one, gives no decodeValid
	noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
		!(fetchValid && !flush) |=> !decodeValid)
	else begin
		$error("decodeValid high without an unflushed strobe the cycle before");
		assertFails++;
	end

	// outputs still clear on the first edge out of reset
	resetClears: assert property (@(posedge clk)
		$rose(arstN) |-> !decodeValid && dataD == '0)
	else begin
		$error("decodeValid or dataD not cleared by reset");
		assertFails++;
	end

endmodule

bind decodeStage decodeStage_checker u_checker (.*);

/* verif/decodeStageTb.sv */
`timescale 1ns/100ps

module decodeStageTb import mipsPkg::*; ();

	localparam int PERIOD = 8;
	localparam int NUM_VECTORS = 4000;
	localparam int MARGIN = 100 * PERIOD;

	// one row per supported encoding
	typedef struct packed {
		decodedOp_t op;
		logic [5:0] opc;
		// func field for special and rs field for cop0
		logic [5:0] sub;
		control_t ctl;
		// bit 3 reads rs and bit 2 reads rt
		// low bits pick the destination as none rt rd ra
		logic [3:0] regs;
	} opEntry_t;

	logic clk;
	logic arstN;
	logic fetchValid;
	logic flush;
	fetch_data_t dataF;
	logic decodeValid;
	decode_data_t dataD;

	opEntry_t opTable[$];
	decode_data_t expQ[$];
	word_t seed = 32'hf467_e73d;
	int errors = 0;

	decodeStage u_dut (.*);

	// lcg step with the high half folded into the low bits
	function automatic word_t nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 16);
	endfunction

	task automatic addEntry(input decodedOp_t op, input logic [5:0] opc, input logic [5:0] sub,
			input logic [11:0] ctl, input logic [3:0] regs);
		opTable.push_back(opEntry_t'({op, opc, sub, ctl, regs}));
	endtask

	// ctl bits in struct order regWrite memRead memWrite branch jump jumpReg aluSrcImm
	// zeroExt link useShamt isCp0 isCache
	task automatic buildTable();
		addEntry(DEC_SLL, 6'h00, 6'h00, 12'b1000_0000_0100, 4'b0110);
		addEntry(DEC_SRL, 6'h00, 6'h02, 12'b1000_0000_0100, 4'b0110);
		addEntry(DEC_JR, 6'h00, 6'h08, 12'b0000_1100_0000, 4'b1000);
		addEntry(DEC_ADDU, 6'h00, 6'h21, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_SUBU, 6'h00, 6'h23, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_AND, 6'h00, 6'h24, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_OR, 6'h00, 6'h25, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_XOR, 6'h00, 6'h26, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_SLT, 6'h00, 6'h2a, 12'b1000_0000_0000, 4'b1110);
		addEntry(DEC_J, 6'h02, 6'h00, 12'b0000_1000_0000, 4'b0000);
		addEntry(DEC_JAL, 6'h03, 6'h00, 12'b1000_1000_1000, 4'b0011);
		addEntry(DEC_BEQ, 6'h04, 6'h00, 12'b0001_0000_0000, 4'b1100);
		addEntry(DEC_BNE, 6'h05, 6'h00, 12'b0001_0000_0000, 4'b1100);
		addEntry(DEC_ADDIU, 6'h09, 6'h00, 12'b1000_0010_0000, 4'b1001);
		addEntry(DEC_SLTI, 6'h0a, 6'h00, 12'b1000_0010_0000, 4'b1001);
		addEntry(DEC_ANDI, 6'h0c, 6'h00, 12'b1000_0011_0000, 4'b1001);
		addEntry(DEC_ORI, 6'h0d, 6'h00, 12'b1000_0011_0000, 4'b1001);
		addEntry(DEC_XORI, 6'h0e, 6'h00, 12'b1000_0011_0000, 4'b1001);
		addEntry(DEC_LUI, 6'h0f, 6'h00, 12'b1000_0010_0000, 4'b0001);
		addEntry(DEC_LW, 6'h23, 6'h00, 12'b1100_0010_0000, 4'b1001);
		addEntry(DEC_SW, 6'h2b, 6'h00, 12'b0010_0010_0000, 4'b1100);
		addEntry(DEC_CACHE, 6'h2f, 6'h00, 12'b0000_0010_0001, 4'b1000);
		addEntry(DEC_MFC0, 6'h10, 6'h00, 12'b1000_0000_0010, 4'b0001);
		addEntry(DEC_MTC0, 6'h10, 6'h04, 12'b0000_0000_0010, 4'b0100);
	endtask

	// reference model of the whole decode bundle
	function automatic decode_data_t expectDecode(input fetch_data_t f);
		decode_data_t d;
		word_t sImm;
		logic hit;
		d = '0;
		sImm = {{16{f.instr[15]}}, f.instr[15:0]};
		d.instr.op = DEC_RESERVED;
		d.exceptionRi = 1'b1;
		foreach (opTable[i]) begin
			// special also matches func and cop0 also matches rs
			hit = (opTable[i].opc == f.instr[31:26]);
			if (opTable[i].opc == 6'h00) begin
				hit = hit && (opTable[i].sub == f.instr[5:0]);
			end else if (opTable[i].opc == 6'h10) begin
				hit = hit && (opTable[i].sub[4:0] == f.instr[25:21]);
			end
			if (hit) begin
				d.instr.op = opTable[i].op;
				d.instr.ctl = opTable[i].ctl;
				d.exceptionRi = 1'b0;
				d.srcRegA = opTable[i].regs[3] ? f.instr[25:21] : 5'd0;
				d.srcRegB = opTable[i].regs[2] ? f.instr[20:16] : 5'd0;
				case (opTable[i].regs[1:0])
					2'd1: d.destReg = f.instr[20:16];
					2'd2: d.destReg = f.instr[15:11];
					2'd3: d.destReg = RA_REG;
					default: d.destReg = 5'd0;
				endcase
			end
		end
		// all-zero word is the nop and writes nothing back
		if (f.instr == 32'h0) begin
			d.instr.ctl.regWrite = 1'b0;
		end
		d.instr.shamt = f.instr[10:6];
		d.instr.extendedImm = d.instr.ctl.zeroExt ? {16'h0, f.instr[15:0]} : sImm;
		d.instr.pcBranch = f.pcPlus4 + (sImm << 2);
		d.instr.pcJump = {f.pcPlus4[31:28], f.instr[25:0], 2'b00};
		d.instr.cacheOp = f.instr[20:16];
		d.cp0Addr = f.instr[15:11];
		d.cp0Sel = f.instr[2:0];
		d.pcPlus4 = f.pcPlus4;
		d.pred = f.pred;
		d.jrTop = f.jrTop;
		d.exceptionInstr = f.exceptionInstr;
		d.instrTlbInvalid = f.instrTlbInvalid;
		d.instrTlbRefill = f.instrTlbRefill;
		return d;
	endfunction

	task automatic checkField(input string name, input logic [255:0] expVal,
			input logic [255:0] actVal);
		assert (actVal === expVal)
		else begin
			errors++;
			$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
		end
	endtask

	// outputs settled since the last rising edge
	task automatic checkOutputs();
		decode_data_t e;
		checkField("decodeValid", expQ.size() != 0, decodeValid);
		if (decodeValid && expQ.size() != 0) begin
			e = expQ.pop_front();
			checkField("op", e.instr.op, dataD.instr.op);
			checkField("ctl", e.instr.ctl, dataD.instr.ctl);
			checkField("srcRegA", e.srcRegA, dataD.srcRegA);
			checkField("srcRegB", e.srcRegB, dataD.srcRegB);
			checkField("destReg", e.destReg, dataD.destReg);
			checkField("exceptionRi", e.exceptionRi, dataD.exceptionRi);
			checkField("extendedImm", e.instr.extendedImm, dataD.instr.extendedImm);
			checkField("pcBranch", e.instr.pcBranch, dataD.instr.pcBranch);
			checkField("pcJump", e.instr.pcJump, dataD.instr.pcJump);
			// catches slices and pass-through fields
			checkField("dataD", e, dataD);
		end
		expQ.delete();
	endtask

	// mostly table encodings with some random words and the odd nop
	task automatic driveInputs();
		fetch_data_t f;
		word_t r;
		opEntry_t e;
		f.instr = nextRand();
		r = nextRand();
		f.pcPlus4 = {r[31:2], 2'b00};
		r = nextRand();
		{f.pred, f.jrTop, f.exceptionInstr, f.instrTlbInvalid, f.instrTlbRefill} = r[4:0];
		if (r[31:28] < 4'd12) begin
			e = opTable[nextRand() % opTable.size()];
			f.instr[31:26] = e.opc;
			if (e.opc == 6'h00) begin
				f.instr[5:0] = e.sub;
			end else if (e.opc == 6'h10) begin
				f.instr[25:21] = e.sub[4:0];
			end
		end else if (r[31:28] == 4'd15) begin
			f.instr = 32'h0;
		end
		fetchValid = (r[23:22] != 2'b00);
		flush = (r[19:17] == 3'b000);
		dataF = f;
		if (fetchValid && !flush) begin
			expQ.push_back(expectDecode(f));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// watchdog
	initial begin
		#((NUM_VECTORS + 16) * PERIOD + MARGIN);
		$display("timeout, stimulus did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		arstN = 1'b0;
		fetchValid = 1'b0;
		flush = 1'b0;
		dataF = '0;
		buildTable();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		checkField("decodeValid", 1'b0, decodeValid);
		checkField("dataD", '0, dataD);
		repeat (NUM_VECTORS) begin
			@(negedge clk);
			checkOutputs();
			driveInputs();
		end
		@(negedge clk);
		checkOutputs();
		fetchValid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		$display("compare errors %0d, assertion errors %0d", errors, u_dut.u_checker.assertFails);
		if (errors == 0 && u_dut.u_checker.assertFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* mipsDecode.f */
design/mipsPkg.sv
design/mainDecode.sv
design/targetCalc.sv
design/decodeLatch.sv
design/decodeStage.sv
verif/decodeStage_checker.sv
verif/decodeStageTb.sv
